// File: Makefile
TOP = decode_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -Wno-fatal -f verilog.f --top-module $(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

// File: tests/decode_tb.sv
// directed testbench for the RV32I decode stage
// immediates, writeback, scoreboard stalls, back-pressure, system stream and flags
`timescale 1ns/1ns

module decode_tb;

    localparam int TIMEOUT_CYCLES = 3000;

    logic                              clk = 1'b0;
    logic                              rst;
    logic                              instr_valid, instr_ready;
    decode_pkg::instr_t                instr_data;
    logic [decode_pkg::DATA_W-1:0]     instr_pc;
    logic                              wb_valid;
    logic [decode_pkg::REG_ADDR_W-1:0] wb_addr;
    logic [decode_pkg::DATA_W-1:0]     wb_value;
    logic                              exec_valid, exec_ready;
    logic [6:0]                        exec_opcode, exec_funct7;
    logic [2:0]                        exec_funct3;
    logic [decode_pkg::REG_ADDR_W-1:0] exec_rd;
    logic [decode_pkg::DATA_W-1:0]     exec_rs1_value, exec_rs2_value, exec_imm, exec_pc;
    logic                              sys_valid, sys_ready;
    logic [2:0]                        sys_funct3;
    logic [decode_pkg::CSR_W-1:0]      sys_csr;
    logic [decode_pkg::REG_ADDR_W-1:0] sys_rd;
    logic [decode_pkg::DATA_W-1:0]     sys_operand;
    logic                              exit_flag, error_flag;

    int                                errors;
    int                                cycles;
    integer                            seed;
    logic [decode_pkg::DATA_W-1:0]     v5;

    decode_top uut (
        .clk, .rst,
        .instr_valid, .instr_data, .instr_pc, .instr_ready,
        .wb_valid, .wb_addr, .wb_value,
        .exec_valid, .exec_opcode, .exec_funct3, .exec_funct7, .exec_rd,
        .exec_rs1_value, .exec_rs2_value, .exec_imm, .exec_pc, .exec_ready,
        .sys_valid, .sys_funct3, .sys_csr, .sys_rd, .sys_operand, .sys_ready,
        .exit_flag, .error_flag
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic check_word(input string name, input logic [decode_pkg::DATA_W-1:0] got,
                              input logic [decode_pkg::DATA_W-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_reg(input string name, input logic [decode_pkg::REG_ADDR_W-1:0] got,
                             input logic [decode_pkg::REG_ADDR_W-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // opcode, funct and csr fields, zero-extended
    task automatic check_field(input string name, input logic [11:0] got,
                               input logic [11:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    function automatic decode_pkg::instr_t encode_r(input logic [6:0] opc, input logic [2:0] f3,
            input logic [6:0] f7, input logic [4:0] rd, input logic [4:0] rs1,
            input logic [4:0] rs2);
        decode_pkg::instr_t w;
        w.r = {f7, rs2, rs1, f3, rd, opc};
        return w;
    endfunction

    function automatic decode_pkg::instr_t encode_i(input logic [6:0] opc, input logic [2:0] f3,
            input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
        decode_pkg::instr_t w;
        w.i = {imm, rs1, f3, rd, opc};
        return w;
    endfunction

    function automatic decode_pkg::instr_t encode_s(input logic [2:0] f3, input logic [4:0] rs1,
            input logic [4:0] rs2, input logic [11:0] imm);
        decode_pkg::instr_t w;
        w.s = {imm[11:5], rs2, rs1, f3, imm[4:0], decode_pkg::OPC_STORE};
        return w;
    endfunction

    // branch offset bits 12|10:5 and 4:1|11
    function automatic decode_pkg::instr_t encode_b(input logic [2:0] f3, input logic [4:0] rs1,
            input logic [4:0] rs2, input logic [12:0] imm);
        decode_pkg::instr_t w;
        w.s = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], decode_pkg::OPC_BRANCH};
        return w;
    endfunction

    function automatic decode_pkg::instr_t encode_u(input logic [6:0] opc, input logic [4:0] rd,
            input logic [19:0] upper);
        decode_pkg::instr_t w;
        w.u = {upper, rd, opc};
        return w;
    endfunction

    // jump offset bits 20|10:1|11|19:12
    function automatic decode_pkg::instr_t encode_j(input logic [4:0] rd,
            input logic [20:0] imm);
        decode_pkg::instr_t w;
        w.u = {imm[20], imm[10:1], imm[11], imm[19:12], rd, decode_pkg::OPC_JAL};
        return w;
    endfunction

    task automatic start_instr(input decode_pkg::instr_t w, input logic [31:0] pc);
        @(negedge clk);
        instr_valid = 1'b1;
        instr_data  = w;
        instr_pc    = pc;
    endtask

    // returns on the falling edge after the transfer, with valid and writeback dropped
    task automatic wait_accept(input int limit, input string what);
        int waited;
        waited = 0;
        #1;
        while (!instr_ready && waited < limit) begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (!instr_ready) begin
            errors++;
            $display("%s was not accepted within %0d cycles", what, limit);
        end
        @(posedge clk);
        @(negedge clk);
        instr_valid = 1'b0;
        wb_valid    = 1'b0;
    endtask

    task automatic send(input decode_pkg::instr_t w, input logic [31:0] pc, input string what);
        start_instr(w, pc);
        wait_accept(20, what);
    endtask

    task automatic expect_stall(input int n);
        repeat (n) begin
            #1;
            check_bit("instr_ready", instr_ready, 1'b0);
            @(negedge clk);
        end
    endtask

    task automatic write_back(input logic [4:0] addr, input logic [31:0] value);
        @(negedge clk);
        wb_valid = 1'b1;
        wb_addr  = addr;
        wb_value = value;
        @(negedge clk);
        wb_valid = 1'b0;
    endtask

    task automatic expect_exec(input decode_pkg::instr_t w, input logic [31:0] rs1v,
            input logic [31:0] rs2v, input logic [31:0] immv, input logic [31:0] pcv);
        check_bit("exec_valid", exec_valid, 1'b1);
        check_bit("sys_valid", sys_valid, 1'b0);
        check_field("exec_opcode", 12'(exec_opcode), 12'(w.r.opcode));
        check_field("exec_funct3", 12'(exec_funct3), 12'(w.r.funct3));
        check_field("exec_funct7", 12'(exec_funct7), 12'(w.r.funct7));
        check_reg("exec_rd", exec_rd, w.r.rd);
        check_word("exec_rs1_value", exec_rs1_value, rs1v);
        check_word("exec_rs2_value", exec_rs2_value, rs2v);
        check_word("exec_imm", exec_imm, immv);
        check_word("exec_pc", exec_pc, pcv);
    endtask

    task automatic expect_sys(input decode_pkg::instr_t w, input logic [31:0] operand);
        check_bit("sys_valid", sys_valid, 1'b1);
        check_bit("exec_valid", exec_valid, 1'b0);
        check_field("sys_funct3", 12'(sys_funct3), 12'(w.i.funct3));
        check_field("sys_csr", sys_csr, w.i.imm_11_0);
        check_reg("sys_rd", sys_rd, w.i.rd);
        check_word("sys_operand", sys_operand, operand);
    endtask

    task automatic check_reset_outputs();
        check_bit("instr_ready", instr_ready, 1'b0);
        check_bit("exec_valid", exec_valid, 1'b0);
        check_bit("sys_valid", sys_valid, 1'b0);
        check_bit("exit_flag", exit_flag, 1'b0);
        check_bit("error_flag", error_flag, 1'b0);
    endtask

    task automatic test_immediates();
        decode_pkg::instr_t w;
        int off;
        // first instruction waits out the register sweep
        off = -5;
        w = encode_i(decode_pkg::OPC_OP_IMM, 3'b000, 5'd1, 5'd0, off[11:0]);
        start_instr(w, 32'h100);
        expect_stall(30);
        wait_accept(10, "ADDI after the sweep");
        expect_exec(w, '0, '0, off, 32'h100);
        off = -12;
        w = encode_s(3'b010, 5'd0, 5'd0, off[11:0]);
        send(w, 32'h104, "SW");
        expect_exec(w, '0, '0, off, 32'h104);
        off = -260;
        w = encode_b(3'b000, 5'd0, 5'd0, off[12:0]);
        send(w, 32'h108, "BEQ");
        expect_exec(w, '0, '0, off, 32'h108);
        w = encode_u(decode_pkg::OPC_LUI, 5'd4, 20'habcde);
        send(w, 32'h10c, "LUI");
        expect_exec(w, '0, '0, 32'habcde000, 32'h10c);
        off = -74566;
        w = encode_j(5'd7, off[20:0]);
        send(w, 32'h110, "JAL");
        expect_exec(w, '0, '0, off, 32'h110);
    endtask

    task automatic test_writeback();
        decode_pkg::instr_t w;
        logic [31:0] v6;
        v5 = $random(seed);
        v6 = $random(seed);
        write_back(5'd5, v5);
        write_back(5'd6, v6);
        write_back(5'd0, 32'hffffffff);
        w = encode_r(decode_pkg::OPC_OP, 3'b000, 7'h00, 5'd8, 5'd5, 5'd6);
        send(w, 32'h120, "ADD x8");
        expect_exec(w, v5, v6, '0, 32'h120);
        // x0 keeps reading zero
        w = encode_r(decode_pkg::OPC_OP, 3'b000, 7'h20, 5'd9, 5'd0, 5'd5);
        send(w, 32'h124, "SUB x9");
        expect_exec(w, '0, v5, '0, 32'h124);
    endtask

    task automatic test_scoreboard();
        decode_pkg::instr_t w;
        logic [31:0] v3;
        v3 = $random(seed);
        w = encode_i(decode_pkg::OPC_OP_IMM, 3'b000, 5'd3, 5'd0, 12'd1);
        send(w, 32'h140, "ADDI to x3");
        expect_exec(w, '0, '0, 32'd1, 32'h140);
        w = encode_r(decode_pkg::OPC_OP, 3'b000, 7'h00, 5'd10, 5'd3, 5'd5);
        start_instr(w, 32'h144);
        expect_stall(5);
        wb_valid = 1'b1;
        wb_addr  = 5'd3;
        wb_value = v3;
        wait_accept(0, "ADD with x3 on the writeback port");
        expect_exec(w, v3, v5, '0, 32'h144);
        w = encode_i(decode_pkg::OPC_OP_IMM, 3'b000, 5'd3, 5'd0, 12'd2);
        send(w, 32'h148, "ADDI to x3 again");
        expect_exec(w, '0, '0, 32'd2, 32'h148);
        // second writer waits until x3 is written back
        w = encode_i(decode_pkg::OPC_OP_IMM, 3'b000, 5'd3, 5'd0, 12'd3);
        start_instr(w, 32'h14c);
        expect_stall(5);
        write_back(5'd3, v3);
        wait_accept(1, "second writer of x3");
        expect_exec(w, '0, '0, 32'd3, 32'h14c);
        write_back(5'd3, v3);
    endtask

    task automatic test_backpressure();
        decode_pkg::instr_t first;
        decode_pkg::instr_t second;
        exec_ready = 1'b0;
        first = encode_i(decode_pkg::OPC_OP_IMM, 3'b000, 5'd11, 5'd0, 12'h011);
        send(first, 32'h200, "first ADDI under back-pressure");
        expect_exec(first, '0, '0, 32'h11, 32'h200);
        second = encode_i(decode_pkg::OPC_OP_IMM, 3'b000, 5'd12, 5'd0, 12'h022);
        start_instr(second, 32'h204);
        repeat (5) begin
            #1;
            check_bit("instr_ready", instr_ready, 1'b0);
            check_bit("exec_valid", exec_valid, 1'b1);
            check_word("exec_imm", exec_imm, 32'h11);
            check_word("exec_pc", exec_pc, 32'h200);
            @(negedge clk);
        end
        exec_ready = 1'b1;
        wait_accept(1, "second ADDI after release");
        expect_exec(second, '0, '0, 32'h22, 32'h204);
    endtask

    task automatic test_system();
        decode_pkg::instr_t w;
        logic [31:0] v2;
        v2 = $random(seed);
        write_back(5'd2, v2);
        w = encode_i(decode_pkg::OPC_SYSTEM, 3'b001, 5'd13, 5'd2, 12'h300);
        send(w, 32'h300, "CSRRW");
        expect_sys(w, v2);
        w = encode_i(decode_pkg::OPC_SYSTEM, 3'b101, 5'd14, 5'h15, 12'h305);
        send(w, 32'h304, "CSRRWI");
        expect_sys(w, 32'h15);
    endtask

    task automatic test_flags();
        decode_pkg::instr_t w;
        w = encode_i(7'b1011011, 3'b000, 5'd16, 5'd0, 12'h000);
        send(w, 32'h400, "illegal opcode");
        check_bit("exec_valid", exec_valid, 1'b0);
        check_bit("sys_valid", sys_valid, 1'b0);
        check_bit("error_flag", error_flag, 1'b1);
        check_bit("exit_flag", exit_flag, 1'b0);
        w = encode_i(decode_pkg::OPC_SYSTEM, 3'b000, 5'd0, 5'd0, 12'h000);
        send(w, 32'h404, "ECALL");
        check_bit("exit_flag", exit_flag, 1'b1);
        check_bit("error_flag", error_flag, 1'b1);
        check_bit("exec_valid", exec_valid, 1'b0);
        // dropped once the stage has exited
        w = encode_i(decode_pkg::OPC_OP_IMM, 3'b000, 5'd15, 5'd0, 12'd1);
        send(w, 32'h408, "ADDI after exit");
        check_bit("exec_valid", exec_valid, 1'b0);
        check_bit("sys_valid", sys_valid, 1'b0);
    endtask

    initial begin
        seed        = 55996;
        errors      = 0;
        cycles      = 0;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr_data  = '0;
        instr_pc    = '0;
        wb_valid    = 1'b0;
        wb_addr     = '0;
        wb_value    = '0;
        exec_ready  = 1'b1;
        sys_ready   = 1'b1;
        repeat (10) @(negedge clk);
        check_reset_outputs();
        rst = 1'b0;
        test_immediates();
        test_writeback();
        test_scoreboard();
        test_backpressure();
        test_system();
        test_flags();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
verilog/decode_pkg.sv
verilog/decode_regfile.sv
verilog/instr_classify.sv
verilog/decode_control.sv
verilog/dispatch_stage.sv
verilog/decode_top.sv
tests/decode_tb.sv

// File: verilog/decode_control.sv
// decode control
// sweep/normal/exit FSM, scoreboard hazard check with writeback bypass, issue and flags
`timescale 1ns/1ns

module decode_control (
    input  logic                              clk,
    input  logic                              rst,

    input  logic                              instr_valid,
    input  decode_pkg::instr_t                instr_data,
    input  logic [decode_pkg::DATA_W-1:0]     instr_pc,
    output logic                              instr_ready,

    input  logic [decode_pkg::DATA_W-1:0]     rs1_value,
    input  logic [decode_pkg::DATA_W-1:0]     rs2_value,
    input  logic                              rs1_busy,
    input  logic                              rs2_busy,
    input  logic                              rd_busy,
    input  logic                              sweep_done,

    input  logic                              wb_valid,
    input  logic [decode_pkg::REG_ADDR_W-1:0] wb_addr,
    input  logic [decode_pkg::DATA_W-1:0]     wb_value,
    output logic                              reserve,

    input  logic                              exec_accept,
    input  logic                              sys_accept,
    output logic                              exec_load,
    output logic [decode_pkg::EXEC_OP_W-1:0]  exec_payload,
    output logic                              sys_load,
    output logic [decode_pkg::SYS_OP_W-1:0]   sys_payload,

    output logic                              exit_flag,
    output logic                              error_flag
);

    typedef enum logic [1:0] {
        ST_RESET,
        ST_NORMAL,
        ST_EXIT
    } state_t;

    state_t                        state;
    logic                          to_execute, to_system, is_exit, is_illegal;
    logic                          uses_rs1, uses_rs2, writes_rd;
    logic [decode_pkg::DATA_W-1:0] imm;
    logic                          rs1_hit, rs2_hit, operands_ok, target_ok, dropped;
    logic [decode_pkg::DATA_W-1:0] rs1_op, rs2_op, sys_operand;

    instr_classify classify (
        .instr(instr_data),
        .to_execute, .to_system, .is_exit, .is_illegal,
        .uses_rs1, .uses_rs2, .writes_rd,
        .imm
    );

    // writeback in this cycle satisfies a waiting source
    assign rs1_hit = wb_valid && wb_addr != '0 && wb_addr == instr_data.r.rs1;
    assign rs2_hit = wb_valid && wb_addr != '0 && wb_addr == instr_data.r.rs2;

    assign rs1_op = !uses_rs1 ? '0 : (rs1_hit ? wb_value : rs1_value);
    assign rs2_op = !uses_rs2 ? '0 : (rs2_hit ? wb_value : rs2_value);

    assign operands_ok = (!uses_rs1 || !rs1_busy || rs1_hit) &&
                         (!uses_rs2 || !rs2_busy || rs2_hit) &&
                         (!writes_rd || instr_data.r.rd == '0 || !rd_busy);
    assign target_ok   = to_execute ? exec_accept : (to_system ? sys_accept : 1'b1);
    assign dropped     = is_exit || is_illegal;

    always_comb begin
        case (state)
            ST_NORMAL: instr_ready = instr_valid && (dropped || (operands_ok && target_ok));
            ST_EXIT:   instr_ready = instr_valid;
            default:   instr_ready = 1'b0;
        endcase
    end

    assign exec_load = (state == ST_NORMAL) && instr_ready && to_execute;
    assign sys_load  = (state == ST_NORMAL) && instr_ready && to_system;
    assign reserve   = (exec_load || sys_load) && writes_rd;
    assign exit_flag = (state == ST_EXIT);

    // zimm forms send the rs1 field itself
    assign sys_operand = instr_data.i.funct3[2] ?
                         decode_pkg::DATA_W'(instr_data.i.rs1) : rs1_op;

    assign exec_payload = {instr_data.r.opcode, instr_data.r.funct3, instr_data.r.funct7,
                           instr_data.r.rd, rs1_op, rs2_op, imm, instr_pc};
    assign sys_payload  = {instr_data.i.funct3, instr_data.i.imm_11_0, instr_data.i.rd,
                           sys_operand};

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_RESET;
            error_flag <= 1'b0;
        end else begin
            case (state)
                ST_RESET:  if (sweep_done) state <= ST_NORMAL;
                ST_NORMAL: if (instr_ready && is_exit) state <= ST_EXIT;
                default:   state <= state;
            endcase
            // sticky until reset
            if (state == ST_NORMAL && instr_ready && is_illegal) begin
                error_flag <= 1'b1;
            end
        end
    end

    // dispatch only after the sweep, for a legal non-exit word, into one stream
    assert property (@(posedge clk) disable iff (rst)
        (exec_load || sys_load) |-> sweep_done && !dropped && !(exec_load && sys_load));

endmodule

// File: verilog/decode_pkg.sv
// decode stage shared definitions
// widths, RV32I major opcodes and the instruction word layouts
package decode_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int CSR_W      = 12;

    // RV32I major opcodes
    localparam logic [6:0] OPC_LUI      = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_LOAD     = 7'b0000011;
    localparam logic [6:0] OPC_STORE    = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_OP       = 7'b0110011;
    localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
    localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

    // opcode, funct3, funct7, rd, rs1, rs2, imm, pc
    localparam int EXEC_OP_W = 7 + 3 + 7 + REG_ADDR_W + 4 * DATA_W;
    // funct3, csr, rd, operand
    localparam int SYS_OP_W  = 3 + CSR_W + REG_ADDR_W + DATA_W;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm_11_0;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_11_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_4_0;
        logic [6:0]            opcode;
    } s_fmt_t;

    typedef struct packed {
        logic [19:0]           imm_31_12;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } u_fmt_t;

    // one instruction word, four views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        u_fmt_t u;
    } instr_t;

endpackage

// File: verilog/decode_regfile.sv
// decode register file
// holds register values and busy bits, cleared by a sweep after reset
`timescale 1ns/1ns

module decode_regfile (
    input  logic                              clk,
    input  logic                              rst,

    input  logic [decode_pkg::REG_ADDR_W-1:0] rs1_addr,
    input  logic [decode_pkg::REG_ADDR_W-1:0] rs2_addr,
    output logic [decode_pkg::DATA_W-1:0]     rs1_value,
    output logic [decode_pkg::DATA_W-1:0]     rs2_value,
    output logic                              rs1_busy,
    output logic                              rs2_busy,
    output logic                              rd_busy,

    input  logic [decode_pkg::REG_ADDR_W-1:0] rd_addr,
    input  logic                              reserve,

    input  logic                              wb_valid,
    input  logic [decode_pkg::REG_ADDR_W-1:0] wb_addr,
    input  logic [decode_pkg::DATA_W-1:0]     wb_value,

    output logic                              sweep_done
);

    logic [decode_pkg::DATA_W-1:0]     regs [decode_pkg::NUM_REGS];
    logic [decode_pkg::NUM_REGS-1:0]   busy;
    logic [decode_pkg::REG_ADDR_W-1:0] sweep_idx;
    logic                              wb_write;

    assign wb_write = wb_valid && (wb_addr != '0);

    // x0 always reads zero
    assign rs1_value = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_value = (rs2_addr == '0) ? '0 : regs[rs2_addr];
    assign rs1_busy  = busy[rs1_addr];
    assign rs2_busy  = busy[rs2_addr];
    assign rd_busy   = busy[rd_addr];

    always_ff @(posedge clk) begin
        if (!sweep_done) begin
            regs[sweep_idx] <= '0;
        end else if (wb_write) begin
            regs[wb_addr] <= wb_value;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sweep_idx  <= '0;
            sweep_done <= 1'b0;
        end else if (!sweep_done) begin
            busy[sweep_idx] <= 1'b0;
            sweep_idx       <= sweep_idx + 1'b1;
            sweep_done      <= (int'(sweep_idx) == decode_pkg::NUM_REGS - 1);
        end else begin
            if (wb_write) begin
                busy[wb_addr] <= 1'b0;
            end
            // a reservation wins over a writeback to the same register
            if (reserve && rd_addr != '0) begin
                busy[rd_addr] <= 1'b1;
            end
        end
    end

    // a new reservation only lands on a free register after the sweep
    assert property (@(posedge clk) disable iff (rst)
        reserve |-> sweep_done && !rd_busy);

endmodule

// File: verilog/decode_top.sv
// RV32I decode stage top level
// register file, control and one dispatch stage per output stream
`timescale 1ns/1ns

module decode_top (
    input  logic                              clk,
    input  logic                              rst,

    input  logic                              instr_valid,
    input  logic [decode_pkg::DATA_W-1:0]     instr_data,
    input  logic [decode_pkg::DATA_W-1:0]     instr_pc,
    output logic                              instr_ready,

    input  logic                              wb_valid,
    input  logic [decode_pkg::REG_ADDR_W-1:0] wb_addr,
    input  logic [decode_pkg::DATA_W-1:0]     wb_value,

    output logic                              exec_valid,
    output logic [6:0]                        exec_opcode,
    output logic [2:0]                        exec_funct3,
    output logic [6:0]                        exec_funct7,
    output logic [decode_pkg::REG_ADDR_W-1:0] exec_rd,
    output logic [decode_pkg::DATA_W-1:0]     exec_rs1_value,
    output logic [decode_pkg::DATA_W-1:0]     exec_rs2_value,
    output logic [decode_pkg::DATA_W-1:0]     exec_imm,
    output logic [decode_pkg::DATA_W-1:0]     exec_pc,
    input  logic                              exec_ready,

    output logic                              sys_valid,
    output logic [2:0]                        sys_funct3,
    output logic [decode_pkg::CSR_W-1:0]      sys_csr,
    output logic [decode_pkg::REG_ADDR_W-1:0] sys_rd,
    output logic [decode_pkg::DATA_W-1:0]     sys_operand,
    input  logic                              sys_ready,

    output logic                              exit_flag,
    output logic                              error_flag
);

    decode_pkg::instr_t                 instr_word;
    logic [decode_pkg::DATA_W-1:0]      rs1_value, rs2_value;
    logic                               rs1_busy, rs2_busy, rd_busy, sweep_done, reserve;
    logic                               exec_load, exec_accept, sys_load, sys_accept;
    logic [decode_pkg::EXEC_OP_W-1:0]   exec_payload, exec_data;
    logic [decode_pkg::SYS_OP_W-1:0]    sys_payload, sys_data;

    assign instr_word = instr_data;

    decode_regfile regfile (
        .clk, .rst,
        .rs1_addr(instr_word.r.rs1), .rs2_addr(instr_word.r.rs2),
        .rs1_value, .rs2_value, .rs1_busy, .rs2_busy, .rd_busy,
        .rd_addr(instr_word.r.rd), .reserve,
        .wb_valid, .wb_addr, .wb_value,
        .sweep_done
    );

    decode_control control (
        .clk, .rst,
        .instr_valid, .instr_data(instr_word), .instr_pc, .instr_ready,
        .rs1_value, .rs2_value, .rs1_busy, .rs2_busy, .rd_busy, .sweep_done,
        .wb_valid, .wb_addr, .wb_value, .reserve,
        .exec_accept, .sys_accept,
        .exec_load, .exec_payload, .sys_load, .sys_payload,
        .exit_flag, .error_flag
    );

    dispatch_stage #(.WIDTH(decode_pkg::EXEC_OP_W)) exec_stage (
        .clk, .rst,
        .load(exec_load), .data(exec_payload), .in_ready(exec_accept),
        .out_valid(exec_valid), .out_data(exec_data), .out_ready(exec_ready)
    );

    dispatch_stage #(.WIDTH(decode_pkg::SYS_OP_W)) sys_stage (
        .clk, .rst,
        .load(sys_load), .data(sys_payload), .in_ready(sys_accept),
        .out_valid(sys_valid), .out_data(sys_data), .out_ready(sys_ready)
    );

    // unpack in the order control packs them
    assign {exec_opcode, exec_funct3, exec_funct7, exec_rd,
            exec_rs1_value, exec_rs2_value, exec_imm, exec_pc} = exec_data;
    assign {sys_funct3, sys_csr, sys_rd, sys_operand} = sys_data;

endmodule

// File: verilog/dispatch_stage.sv
// one-entry valid/ready register stage for one dispatch stream
`timescale 1ns/1ns

module dispatch_stage #(
    parameter int WIDTH = decode_pkg::EXEC_OP_W
) (
    input  logic             clk,
    input  logic             rst,

    input  logic             load,
    input  logic [WIDTH-1:0] data,
    output logic             in_ready,

    output logic             out_valid,
    output logic [WIDTH-1:0] out_data,
    input  logic             out_ready
);

    // free when empty or drained this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= load;
        end
    end

    always_ff @(posedge clk) begin
        if (load && in_ready) begin
            out_data <= data;
        end
    end

    // a stalled output holds both valid and data
    assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

// File: verilog/instr_classify.sv
// instruction classifier
// routes an RV32I word to a stream, finds its register use and builds the immediate
`timescale 1ns/1ns

module instr_classify (
    input  decode_pkg::instr_t            instr,
    output logic                          to_execute,
    output logic                          to_system,
    output logic                          is_exit,
    output logic                          is_illegal,
    output logic                          uses_rs1,
    output logic                          uses_rs2,
    output logic                          writes_rd,
    output logic [decode_pkg::DATA_W-1:0] imm
);

    logic [decode_pkg::DATA_W-1:0] imm_i;
    logic [decode_pkg::DATA_W-1:0] imm_s;
    logic [decode_pkg::DATA_W-1:0] imm_b;
    logic [decode_pkg::DATA_W-1:0] imm_u;
    logic [decode_pkg::DATA_W-1:0] imm_j;
    logic [19:0]                   upper;

    assign upper = instr.u.imm_31_12;

    assign imm_i = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
    assign imm_s = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
    // B and J scramble the offset bits of the s and u views
    assign imm_b = {{19{instr.s.imm_11_5[6]}}, instr.s.imm_11_5[6], instr.s.imm_4_0[0],
                    instr.s.imm_11_5[5:0], instr.s.imm_4_0[4:1], 1'b0};
    assign imm_u = {upper, 12'b0};
    assign imm_j = {{11{upper[19]}}, upper[19], upper[7:0], upper[8], upper[18:9], 1'b0};

    always_comb begin
        to_execute = 1'b0;
        to_system  = 1'b0;
        is_exit    = 1'b0;
        is_illegal = 1'b0;
        uses_rs1   = 1'b0;
        uses_rs2   = 1'b0;
        writes_rd  = 1'b0;
        imm        = '0;
        case (instr.r.opcode)
            decode_pkg::OPC_LUI, decode_pkg::OPC_AUIPC: begin
                to_execute = 1'b1;
                writes_rd  = 1'b1;
                imm        = imm_u;
            end
            decode_pkg::OPC_JAL: begin
                to_execute = 1'b1;
                writes_rd  = 1'b1;
                imm        = imm_j;
            end
            decode_pkg::OPC_JALR, decode_pkg::OPC_LOAD, decode_pkg::OPC_OP_IMM: begin
                to_execute = 1'b1;
                uses_rs1   = 1'b1;
                writes_rd  = 1'b1;
                imm        = imm_i;
            end
            decode_pkg::OPC_BRANCH, decode_pkg::OPC_STORE: begin
                to_execute = 1'b1;
                uses_rs1   = 1'b1;
                uses_rs2   = 1'b1;
                imm        = (instr.r.opcode == decode_pkg::OPC_STORE) ? imm_s : imm_b;
            end
            decode_pkg::OPC_OP: begin
                to_execute = 1'b1;
                uses_rs1   = 1'b1;
                uses_rs2   = 1'b1;
                writes_rd  = 1'b1;
            end
            decode_pkg::OPC_MISC_MEM: begin
                to_execute = 1'b1;
                imm        = imm_i;
            end
            decode_pkg::OPC_SYSTEM: begin
                if (instr.i.funct3 == 3'b100) begin
                    is_illegal = 1'b1;
                end else if (instr.i.funct3 != 3'b000) begin
                    to_system = 1'b1;
                    writes_rd = 1'b1;
                    // zimm forms carry no register source
                    uses_rs1  = !instr.i.funct3[2];
                end else if (instr.i.rs1 == '0 && instr.i.rd == '0 &&
                             instr.i.imm_11_0[11:1] == '0) begin
                    is_exit = 1'b1;
                end else begin
                    is_illegal = 1'b1;
                end
            end
            default: is_illegal = 1'b1;
        endcase
    end

endmodule
